/* rtl/display_pkg.sv */
`default_nettype none

package display_pkg;

  // Horizontal timing in pixel clocks
  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = 800;

  // Vertical timing in lines
  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = 525;

  // Pixel coordinate width
  localparam int COORD_W = 10;

  // Colour as {red, green, blue}, two bits each
  localparam logic [5:0] COLOR_BLACK = 6'b00_00_00;
  localparam logic [5:0] COLOR_WHITE = 6'b11_11_11;
  localparam logic [5:0] COLOR_GREEN = 6'b00_11_00;

  // 8x8 bitmaps drawn at double size
  localparam int GLYPH_SIZE = 16;
  localparam int NUM_GLYPHS = 12;

  // Row 0 in the top byte, leftmost column in the MSB of each row
  // Entry order follows the pad frame bit positions, R first, B last
  localparam logic [63:0] GLYPH_BITMAP [0:NUM_GLYPHS-1] = '{
    64'hFCE6E6FCF8FCEE00,  // R
    64'hE0E0E0E0E0FEFE00,  // L
    64'hC3663C18183C66C3,  // X
    64'h3C66667E66666600,  // A
    64'h080C0EFF0E0C0800,  // Right arrow
    64'h103070FF70301000,  // Left arrow
    64'h10101010FE7C3810,  // Down arrow
    64'h10387CFE10101010,  // Up arrow
    64'h185A99999981423C,  // Start
    64'h1824428181422418,  // Select
    64'hC3663C1818181818,  // Y
    64'h7C66667C66667C00   // B
  };

  // Top-left corner of each glyph box, same order as the bitmaps
  localparam logic [COORD_W-1:0] GLYPH_X [0:NUM_GLYPHS-1] = '{
    10'd592, 10'd32, 10'd512, 10'd544, 10'd128, 10'd64,
    10'd96, 10'd96, 10'd328, 10'd264, 10'd480, 10'd512
  };

  localparam logic [COORD_W-1:0] GLYPH_Y [0:NUM_GLYPHS-1] = '{
    10'd100, 10'd100, 10'd200, 10'd240, 10'd240, 10'd240,
    10'd280, 10'd200, 10'd240, 10'd240, 10'd240, 10'd280
  };

endpackage

`default_nettype wire

/* rtl/gamepad_pkg.sv */
`default_nettype none

package gamepad_pkg;

  // Bits in one serial pad frame
  localparam int PAD_BITS = 12;

  // Bit position of each button in the captured frame
  // First bit shifted in lands at BTN_B
  typedef enum logic [3:0] {
    BTN_R      = 4'd0,
    BTN_L      = 4'd1,
    BTN_X      = 4'd2,
    BTN_A      = 4'd3,
    BTN_RIGHT  = 4'd4,
    BTN_LEFT   = 4'd5,
    BTN_DOWN   = 4'd6,
    BTN_UP     = 4'd7,
    BTN_START  = 4'd8,
    BTN_SELECT = 4'd9,
    BTN_Y      = 4'd10,
    BTN_B      = 4'd11
  } button_e;

  // One bit per button, 1 means pressed
  typedef logic [PAD_BITS-1:0] buttons_t;

endpackage

`default_nettype wire

/* rtl/gamepad_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module gamepad_receiver import gamepad_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     pad_data,
  input  logic     pad_clk,
  input  logic     pad_latch,
  output buttons_t buttons
);

  // Two-flop synchronisers, bit 1 is the safe copy
  logic [1:0] data_sync;
  logic [1:0] clk_sync;
  logic [1:0] latch_sync;

  // Previous synchronised levels for edge detection
  logic clk_prev;
  logic latch_prev;

  logic [PAD_BITS-1:0] shift_reg;
  logic [PAD_BITS-1:0] frame;

  logic clk_rise;
  logic latch_rise;

  assign clk_rise   = clk_sync[1] & ~clk_prev;
  assign latch_rise = latch_sync[1] & ~latch_prev;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_sync  <= '0;
      clk_sync   <= '0;
      latch_sync <= '0;
      clk_prev   <= 1'b0;
      latch_prev <= 1'b0;
      // All ones reads as no controller
      shift_reg  <= '1;
      frame      <= '1;
      buttons    <= '0;
    end else begin
      data_sync  <= {data_sync[0], pad_data};
      clk_sync   <= {clk_sync[0], pad_clk};
      latch_sync <= {latch_sync[0], pad_latch};
      clk_prev   <= clk_sync[1];
      latch_prev <= latch_sync[1];

      // MSB first, so the first bit ends up in BTN_B
      if (clk_rise) begin
        shift_reg <= {shift_reg[PAD_BITS-2:0], data_sync[1]};
      end

      // Latch edge freezes the shifted word
      if (latch_rise) begin
        frame <= shift_reg;
      end

      // Absent pad releases every button
      buttons <= (frame == '1) ? '0 : frame;
    end
  end

endmodule

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing import display_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  output logic [COORD_W-1:0] hpos,
  output logic [COORD_W-1:0] vpos,
  output logic               video_active,
  output logic               hsync_raw,
  output logic               vsync_raw
);

  // Sync windows, end is exclusive
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  logic h_last;
  logic v_last;

  assign h_last = (hpos == COORD_W'(H_TOTAL - 1));
  assign v_last = (vpos == COORD_W'(V_TOTAL - 1));

  // Pixel counter every clock, line counter on pixel wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hpos <= '0;
      vpos <= '0;
    end else if (h_last) begin
      hpos <= '0;
      vpos <= v_last ? '0 : vpos + 1'b1;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  assign video_active = (hpos < COORD_W'(H_ACTIVE)) && (vpos < COORD_W'(V_ACTIVE));

  // Both syncs active low
  assign hsync_raw = !((hpos >= COORD_W'(H_SYNC_START)) && (hpos < COORD_W'(H_SYNC_END)));
  assign vsync_raw = !((vpos >= COORD_W'(V_SYNC_START)) && (vpos < COORD_W'(V_SYNC_END)));

  // Counters never leave the frame
  assert property (@(posedge clk) disable iff (!rst_n)
    (hpos < COORD_W'(H_TOTAL)) && (vpos < COORD_W'(V_TOTAL)));

endmodule

`default_nettype wire

/* rtl/cursor_mover.sv */
`timescale 1ns/1ps
`default_nettype none

module cursor_mover import display_pkg::*, gamepad_pkg::*; #(
  parameter int MOVE_DIV_BITS = 14,
  parameter int SQUARE_SIZE   = 16
) (
  input  logic               clk,
  input  logic               rst_n,
  input  buttons_t           buttons,
  input  logic               video_active,
  output logic [COORD_W-1:0] square_x,
  output logic [COORD_W-1:0] square_y
);

  // Largest top-left corner that keeps the square on screen
  localparam logic [COORD_W-1:0] X_LIMIT = COORD_W'(H_ACTIVE - SQUARE_SIZE);
  localparam logic [COORD_W-1:0] Y_LIMIT = COORD_W'(V_ACTIVE - SQUARE_SIZE);

  logic [MOVE_DIV_BITS-1:0] div_cnt;
  logic                     move_tick;
  logic                     go_left;
  logic                     go_right;
  logic                     go_up;
  logic                     go_down;

  // Only step in blanking so a line is never split
  assign move_tick = (div_cnt == '0) && !video_active;

  // Opposite directions cancel
  assign go_left  = buttons[BTN_LEFT] && !buttons[BTN_RIGHT];
  assign go_right = buttons[BTN_RIGHT] && !buttons[BTN_LEFT];
  assign go_up    = buttons[BTN_UP] && !buttons[BTN_DOWN];
  assign go_down  = buttons[BTN_DOWN] && !buttons[BTN_UP];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      square_x <= '0;
      square_y <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      if (move_tick) begin
        // One pixel per tick, held at the edges
        if (go_left && (square_x != '0)) begin
          square_x <= square_x - 1'b1;
        end else if (go_right && (square_x < X_LIMIT)) begin
          square_x <= square_x + 1'b1;
        end
        if (go_up && (square_y != '0)) begin
          square_y <= square_y - 1'b1;
        end else if (go_down && (square_y < Y_LIMIT)) begin
          square_y <= square_y + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (square_x <= X_LIMIT) && (square_y <= Y_LIMIT));

endmodule

`default_nettype wire

/* rtl/pixel_composer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_composer import display_pkg::*, gamepad_pkg::*; #(
  parameter int SQUARE_SIZE = 16
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [COORD_W-1:0] hpos,
  input  logic [COORD_W-1:0] vpos,
  input  logic               video_active,
  input  logic               hsync_raw,
  input  logic               vsync_raw,
  input  buttons_t           buttons,
  input  logic [COORD_W-1:0] square_x,
  input  logic [COORD_W-1:0] square_y,
  output logic               hsync,
  output logic               vsync,
  output logic [1:0]         red,
  output logic [1:0]         green,
  output logic [1:0]         blue
);

  // Glyph index matches the button bit position
  logic [NUM_GLYPHS-1:0] glyph_hit;
  logic                  any_hit;
  logic                  any_pressed;
  logic                  square_hit;
  logic [5:0]            glyph_color;
  logic [5:0]            pixel_color;
  logic [5:0]            color_q;

  for (genvar g = 0; g < NUM_GLYPHS; g++) begin : g_glyph
    logic [COORD_W-1:0] dx;
    logic [COORD_W-1:0] dy;
    logic               in_box;
    logic [5:0]         bit_idx;

    assign dx = hpos - GLYPH_X[g];
    assign dy = vpos - GLYPH_Y[g];
    // Unsigned offsets wrap large when left of or above the box
    assign in_box = (dx < COORD_W'(GLYPH_SIZE)) && (dy < COORD_W'(GLYPH_SIZE));
    // Halve offsets for the 2x scale, row then column
    assign bit_idx = {dy[3:1], dx[3:1]};
    assign glyph_hit[g] = in_box && GLYPH_BITMAP[g][6'd63 - bit_idx];
  end

  assign any_hit     = |glyph_hit;
  assign any_pressed = |(glyph_hit & buttons);

  assign square_hit = (hpos >= square_x) && (hpos < square_x + COORD_W'(SQUARE_SIZE)) &&
                      (vpos >= square_y) && (vpos < square_y + COORD_W'(SQUARE_SIZE));

  // Pressed wins over released
  assign glyph_color = any_pressed ? COLOR_GREEN :
                       any_hit     ? COLOR_WHITE : COLOR_BLACK;

  // Square overlays full green on top of the glyphs
  assign pixel_color = glyph_color | (square_hit ? COLOR_GREEN : COLOR_BLACK);

  // Colour and syncs share one register stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      color_q <= COLOR_BLACK;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
    end else begin
      color_q <= video_active ? pixel_color : COLOR_BLACK;
      hsync   <= hsync_raw;
      vsync   <= vsync_raw;
    end
  end

  assign {red, green, blue} = color_q;

endmodule

`default_nettype wire

/* rtl/gamepad_tester_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gamepad_tester_top import display_pkg::*, gamepad_pkg::*; #(
  parameter int MOVE_DIV_BITS = 14,
  parameter int SQUARE_SIZE   = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pad_data,
  input  logic       pad_clk,
  input  logic       pad_latch,
  output logic       hsync,
  output logic       vsync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue
);

  buttons_t           buttons;
  logic [COORD_W-1:0] hpos;
  logic [COORD_W-1:0] vpos;
  logic               video_active;
  logic               hsync_raw;
  logic               vsync_raw;
  logic [COORD_W-1:0] square_x;
  logic [COORD_W-1:0] square_y;

  // Pad lines are asynchronous to clk
  gamepad_receiver u_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .pad_data  (pad_data),
    .pad_clk   (pad_clk),
    .pad_latch (pad_latch),
    .buttons   (buttons)
  );

  vga_timing u_timing (
    .clk          (clk),
    .rst_n        (rst_n),
    .hpos         (hpos),
    .vpos         (vpos),
    .video_active (video_active),
    .hsync_raw    (hsync_raw),
    .vsync_raw    (vsync_raw)
  );

  cursor_mover #(
    .MOVE_DIV_BITS (MOVE_DIV_BITS),
    .SQUARE_SIZE   (SQUARE_SIZE)
  ) u_cursor (
    .clk          (clk),
    .rst_n        (rst_n),
    .buttons      (buttons),
    .video_active (video_active),
    .square_x     (square_x),
    .square_y     (square_y)
  );

  pixel_composer #(
    .SQUARE_SIZE (SQUARE_SIZE)
  ) u_composer (
    .clk          (clk),
    .rst_n        (rst_n),
    .hpos         (hpos),
    .vpos         (vpos),
    .video_active (video_active),
    .hsync_raw    (hsync_raw),
    .vsync_raw    (vsync_raw),
    .buttons      (buttons),
    .square_x     (square_x),
    .square_y     (square_y),
    .hsync        (hsync),
    .vsync        (vsync),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

endmodule

`default_nettype wire

/* verification/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import display_pkg::*, gamepad_pkg::*; ();

  localparam int MOVE_DIV_BITS  = 10;
  localparam int SQUARE_SIZE    = 16;
  localparam int X_LIMIT        = H_ACTIVE - SQUARE_SIZE;
  localparam int Y_LIMIT        = V_ACTIVE - SQUARE_SIZE;
  localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
  // Longest path is the slow walk to the far corner
  localparam int TIMEOUT_CYCLES = 14 * FRAME_CYCLES;

  logic clk;
  logic rst_n;
  logic pad_data;
  logic pad_clk;
  logic pad_latch;
  logic hsync;
  logic vsync;
  logic [1:0] red;
  logic [1:0] green;
  logic [1:0] blue;

  // Model state mirrors the DUT registers after each rising edge
  int                       m_h;
  int                       m_v;
  int                       m_sx;
  int                       m_sy;
  logic [MOVE_DIV_BITS-1:0] m_div;
  buttons_t                 m_buttons;
  logic [5:0]               exp_color;
  logic                     exp_hs;
  logic                     exp_vs;
  int                       pix_h;
  int                       pix_v;
  logic                     rst_q = 1'b0;
  int                       cycle_count = 0;
  string                    test_name;

  gamepad_tester_top #(
    .MOVE_DIV_BITS (MOVE_DIV_BITS),
    .SQUARE_SIZE   (SQUARE_SIZE)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .pad_data  (pad_data),
    .pad_clk   (pad_clk),
    .pad_latch (pad_latch),
    .hsync     (hsync),
    .vsync     (vsync),
    .red       (red),
    .green     (green),
    .blue      (blue)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic report_failure();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_sync(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s sync at h=%0d v=%0d expected %b actual %b",
               name, pix_h, pix_v, expected, actual);
      report_failure();
    end
  endtask

  task automatic compare_color(input string name, input logic [5:0] expected,
                               input logic [5:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s colour at h=%0d v=%0d expected %b actual %b",
               name, pix_h, pix_v, expected, actual);
      report_failure();
    end
  endtask

  // Expected colour of one active pixel
  function automatic logic [5:0] pixel_color(int h, int v, int sx, int sy, buttons_t btn);
    logic [5:0] c;
    logic       seen;
    logic       lit;
    int         dx;
    int         dy;
    seen = 1'b0;
    lit  = 1'b0;
    for (int i = 0; i < NUM_GLYPHS; i++) begin
      dx = h - int'(GLYPH_X[i]);
      dy = v - int'(GLYPH_Y[i]);
      if (dx >= 0 && dx < GLYPH_SIZE && dy >= 0 && dy < GLYPH_SIZE) begin
        // Each bitmap cell covers 2x2 screen pixels
        if (GLYPH_BITMAP[i][63 - (dy / 2) * 8 - (dx / 2)]) begin
          seen = 1'b1;
          lit  = lit | btn[i];
        end
      end
    end
    c = lit ? COLOR_GREEN : (seen ? COLOR_WHITE : COLOR_BLACK);
    if (h >= sx && h < sx + SQUARE_SIZE && v >= sy && v < sy + SQUARE_SIZE) begin
      c = c | COLOR_GREEN;
    end
    return c;
  endfunction

  task automatic reset_model();
    m_h       = 0;
    m_v       = 0;
    m_sx      = 0;
    m_sy      = 0;
    m_div     = '0;
    m_buttons = '0;
    exp_color = COLOR_BLACK;
    exp_hs    = 1'b1;
    exp_vs    = 1'b1;
  endtask

  // One clock of the display pipeline
  task automatic step_model();
    logic active;
    int   dir_x;
    int   dir_y;
    active = (m_h < H_ACTIVE) && (m_v < V_ACTIVE);
    pix_h  = m_h;
    pix_v  = m_v;
    exp_color = active ? pixel_color(m_h, m_v, m_sx, m_sy, m_buttons) : COLOR_BLACK;
    exp_hs = !(m_h >= H_ACTIVE + H_FRONT && m_h < H_ACTIVE + H_FRONT + H_SYNC);
    exp_vs = !(m_v >= V_ACTIVE + V_FRONT && m_v < V_ACTIVE + V_FRONT + V_SYNC);
    // Opposite buttons sum to zero
    dir_x = int'(m_buttons[BTN_RIGHT]) - int'(m_buttons[BTN_LEFT]);
    dir_y = int'(m_buttons[BTN_DOWN]) - int'(m_buttons[BTN_UP]);
    if (m_div == '0 && !active) begin
      m_sx = (m_sx + dir_x < 0) ? 0 : ((m_sx + dir_x > X_LIMIT) ? X_LIMIT : m_sx + dir_x);
      m_sy = (m_sy + dir_y < 0) ? 0 : ((m_sy + dir_y > Y_LIMIT) ? Y_LIMIT : m_sy + dir_y);
    end
    m_div = m_div + 1'b1;
    m_h   = (m_h + 1) % H_TOTAL;
    if (m_h == 0) begin
      m_v = (m_v + 1) % V_TOTAL;
    end
  endtask

  // Outputs settle long before the falling edge
  always @(negedge clk) begin
    if (!rst_q) begin
      reset_model();
    end else begin
      step_model();
    end
    rst_q = rst_n;
    compare_sync(test_name, {exp_hs, exp_vs}, {hsync, vsync});
    compare_color(test_name, exp_color, {red, green, blue});
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycle_count);
      report_failure();
    end
  end

  // Returns on the first pixel of vertical blanking
  task automatic wait_blanking();
    @(posedge clk);
    while (!(m_v == V_ACTIVE && m_h == 0)) begin
      @(posedge clk);
    end
  endtask

  // First bit out becomes BTN_B
  task automatic send_pad_frame(input buttons_t word);
    wait_blanking();
    for (int i = PAD_BITS - 1; i >= 0; i--) begin
      pad_data <= word[i];
      pad_clk  <= 1'b0;
      repeat (4) @(posedge clk);
      pad_clk  <= 1'b1;
      repeat (4) @(posedge clk);
    end
    pad_clk <= 1'b0;
    // Latch far from a movement tick, so the model can follow a few cycles late
    while (m_div != MOVE_DIV_BITS'(500)) begin
      @(posedge clk);
    end
    pad_latch <= 1'b1;
    repeat (8) @(posedge clk);
    pad_latch <= 1'b0;
    // All ones means no pad, so nothing pressed
    m_buttons = (word == '1) ? '0 : word;
  endtask

  initial begin
    int       seed_val;
    int       rand_word;
    buttons_t word;
    seed_val  = $urandom(32'he158);
    rst_n     = 1'b0;
    pad_data  = 1'b0;
    pad_clk   = 1'b0;
    pad_latch = 1'b0;
    test_name = "reset";
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // No frame yet, glyphs white and square at the origin
    test_name = "idle_frame";

    // Up and down cancel while left presses against the edge
    word = '0;
    word[BTN_UP]   = 1'b1;
    word[BTN_DOWN] = 1'b1;
    word[BTN_LEFT] = 1'b1;
    send_pad_frame(word);
    test_name = "cancel_y_clamp_left";

    // Left and right cancel while up presses against the edge
    word = '0;
    word[BTN_LEFT]  = 1'b1;
    word[BTN_RIGHT] = 1'b1;
    word[BTN_UP]    = 1'b1;
    send_pad_frame(word);
    test_name = "cancel_x_clamp_top";

    // Diagonal walk until both far edges hold the square
    word = '0;
    word[BTN_RIGHT] = 1'b1;
    word[BTN_DOWN]  = 1'b1;
    send_pad_frame(word);
    test_name = "walk_to_corner";
    while (!(m_sx == X_LIMIT && m_sy == Y_LIMIT)) begin
      @(posedge clk);
    end
    test_name = "clamp_far_edges";
    wait_blanking();

    for (int n = 0; n < 2; n++) begin
      rand_word = $urandom;
      word = rand_word[PAD_BITS-1:0];
      send_pad_frame(word);
      test_name = $sformatf("random_buttons_%0d", n);
    end

    send_pad_frame('1);
    test_name = "pad_absent";
    wait_blanking();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/display_pkg.sv
rtl/gamepad_pkg.sv
rtl/gamepad_receiver.sv
rtl/vga_timing.sv
rtl/cursor_mover.sv
rtl/pixel_composer.sv
rtl/gamepad_tester_top.sv
verification/tb_top.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, not the simulator's exit code
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
